// File: src.f
memoryPkg.sv
coherencePkg.sv
ramArbiter.sv
instrFetchPort.sv
coherentDataPort.sv
busController.sv
busController_assertions.sv
busControllerTb.sv

// File: Makefile
# Verilator build and run of the bus controller testbench

TOP := busControllerTb

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless it passes"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) | awk '{ print } /^Finished with no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: busControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module busControllerTb;

    localparam int BLOCK_WORDS = 2;
    localparam int MEM_WORDS = 256;
    localparam memoryPkg::addrT BLOCK_MASK =
        memoryPkg::addrT'(BLOCK_WORDS * memoryPkg::WORD_BYTES - 1);
    // fetches, write-back words, fill words and flush words of all tests
    localparam int ACCESS_COUNT = 6 + 9 * BLOCK_WORDS;
    localparam int TIMEOUT_CYCLES = 40 * ACCESS_COUNT;

    logic                CLK = 1'b0;
    logic                nRST;
    logic [1:0]          iREN;
    memoryPkg::addrT     iaddr [2];
    logic [1:0]          iwait;
    memoryPkg::wordT     iload [2];
    logic [1:0]          dREN;
    logic [1:0]          dWEN;
    memoryPkg::addrT     daddr [2];
    memoryPkg::wordT     dstore [2];
    logic [1:0]          dwait;
    memoryPkg::wordT     dload [2];
    logic [1:0]          ccwrite;
    logic [1:0]          cctrans;
    logic [1:0]          ccwait;
    logic [1:0]          ccinv;
    memoryPkg::addrT     ccsnoopaddr [2];
    logic                ramREN;
    logic                ramWEN;
    memoryPkg::addrT     ramaddr;
    memoryPkg::wordT     ramstore;
    memoryPkg::wordT     ramload;
    memoryPkg::ramStateT ramState;

    memoryPkg::wordT ram [MEM_WORDS];
    memoryPkg::wordT shadow [MEM_WORDS];
    memoryPkg::wordT ownStore [2];
    memoryPkg::wordT snoopStore [2];
    logic [1:0]      modValid;
    memoryPkg::addrT modBase [2];
    memoryPkg::wordT modSeed [2];
    logic [31:0]     lfsr;
    int              busyLeft;
    int              fillIdx [2] = '{0, 0};
    int              invSeen [2] = '{0, 0};
    int              cycles = 0;

    busController #(
        .BLOCK_WORDS(BLOCK_WORDS),
        .FETCH_CORES(2)
    ) uut (
        .CLK(CLK), .nRST(nRST),
        .iREN(iREN), .iaddr(iaddr), .iwait(iwait), .iload(iload),
        .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
        .dwait(dwait), .dload(dload),
        .ccwrite(ccwrite), .cctrans(cctrans), .ccwait(ccwait), .ccinv(ccinv),
        .ccsnoopaddr(ccsnoopaddr),
        .ramREN(ramREN), .ramWEN(ramWEN), .ramaddr(ramaddr), .ramstore(ramstore),
        .ramload(ramload), .ramState(ramState)
    );

    bind busController busControllerAssertions checks (
        .CLK(CLK), .nRST(nRST), .ramREN(ramREN), .ramWEN(ramWEN),
        .dREN(dREN), .dWEN(dWEN), .dwait(dwait), .ccwait(ccwait), .ccinv(ccinv)
    );

    always #10 CLK = ~CLK;

    // snooped core drives its modified word, otherwise the core's own store
    assign dstore[0] = dWEN[0] ? ownStore[0] : snoopStore[0];
    assign dstore[1] = dWEN[1] ? ownStore[1] : snoopStore[1];
    assign ramload = ram[ramaddr[9:2]];

    function automatic memoryPkg::wordT fillWord(int i);
        return 32'(i) * 32'h9e37_79b9 + 32'h1357_9bdf;
    endfunction

    function automatic memoryPkg::wordT blockWord(memoryPkg::wordT seed, int k);
        return seed + 32'(k) * 32'h0101_0101;
    endfunction

    function automatic int wordOffset(memoryPkg::addrT a);
        return int'((a & BLOCK_MASK) / memoryPkg::WORD_BYTES);
    endfunction

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic holdsModified(int c, memoryPkg::addrT a);
        return modValid[c] && ((a & ~BLOCK_MASK) == modBase[c]);
    endfunction

    // expected RAM contents as seen by the cores
    function automatic memoryPkg::wordT expectedWord(memoryPkg::addrT a);
        return shadow[a[9:2]];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fetchWord(input int core, input memoryPkg::addrT a);
        @(posedge CLK);
        #1;
        iREN[core] = 1'b1;
        iaddr[core] = a;
        do @(negedge CLK); while (iwait[core]);
        @(posedge CLK);
        #1;
        iREN[core] = 1'b0;
    endtask

    task automatic writeBack(input int core, input memoryPkg::addrT base,
                             input memoryPkg::wordT seed);
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            shadow[int'(base[9:2]) + k] = blockWord(seed, k);
        end
        @(posedge CLK);
        #1;
        dWEN[core] = 1'b1;
        daddr[core] = base;
        ownStore[core] = blockWord(seed, 0);
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            do @(negedge CLK); while (dwait[core]);
            @(posedge CLK);
            #1;
            if (k == BLOCK_WORDS - 1) begin
                dWEN[core] = 1'b0;
            end else begin
                daddr[core] = base + memoryPkg::addrT'((k + 1) * memoryPkg::WORD_BYTES);
                ownStore[core] = blockWord(seed, k + 1);
            end
        end
    endtask

    task automatic dataMiss(input int core, input memoryPkg::addrT a, input logic write);
        @(posedge CLK);
        #1;
        dREN[core] = 1'b1;
        ccwrite[core] = write;
        daddr[core] = a;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            do @(negedge CLK); while (dwait[core]);
        end
        @(posedge CLK);
        #1;
        dREN[core] = 1'b0;
        ccwrite[core] = 1'b0;
    endtask

    // RAM model with 0 to 3 BUSY cycles per access
    initial begin
        memoryPkg::ramStateT nextRamState;
        logic [1:0] draw;
        ramState = memoryPkg::FREE;
        lfsr = 32'h2aee;
        busyLeft = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = fillWord(i);
        end
        forever begin
            @(negedge CLK);
            if (ramState == memoryPkg::ACCESS) begin
                if (ramWEN) begin
                    ram[ramaddr[9:2]] = ramstore;
                end
                lfsr = lfsrStep(lfsr);
                draw[0] = lfsr[0];
                lfsr = lfsrStep(lfsr);
                draw[1] = lfsr[0];
                busyLeft = int'(draw);
                nextRamState = memoryPkg::BUSY;
            end else if (ramREN || ramWEN) begin
                if (busyLeft == 0) begin
                    nextRamState = memoryPkg::ACCESS;
                end else begin
                    busyLeft--;
                    nextRamState = memoryPkg::BUSY;
                end
            end else begin
                nextRamState = memoryPkg::FREE;
            end
            @(posedge CLK);
            #1;
            ramState = nextRamState;
        end
    end

    // cache models answer the snoop one cycle after ccwait
    initial begin
        logic [1:0] sawWait;
        memoryPkg::addrT sawAddr [2];
        cctrans = '0;
        sawWait = '0;
        for (int c = 0; c < 2; c++) begin
            snoopStore[c] = '0;
            sawAddr[c] = '0;
        end
        forever begin
            @(negedge CLK);
            sawWait = ccwait;
            sawAddr[0] = ccsnoopaddr[0];
            sawAddr[1] = ccsnoopaddr[1];
            @(posedge CLK);
            #1;
            for (int c = 0; c < 2; c++) begin
                cctrans[c] = sawWait[c] && holdsModified(c, sawAddr[c]);
                snoopStore[c] = holdsModified(c, ccsnoopaddr[c]) ?
                                blockWord(modSeed[c], wordOffset(ccsnoopaddr[c])) : '0;
            end
        end
    end

    // compare every completed word with the reference
    always @(negedge CLK) begin
        memoryPkg::addrT wordAddr;
        if (nRST) begin
            for (int c = 0; c < 2; c++) begin
                if (iREN[c] && !iwait[c]) begin
                    checkValue("iload", iload[c], expectedWord(iaddr[c]));
                end
                if (ccinv[c]) begin
                    invSeen[1 - c]++;
                end
            end
            for (int c = 0; c < 2; c++) begin
                if (dREN[c] && !dwait[c]) begin
                    wordAddr = (daddr[c] & ~BLOCK_MASK) +
                               memoryPkg::addrT'(fillIdx[c] * memoryPkg::WORD_BYTES);
                    checkValue("dload", dload[c], expectedWord(wordAddr));
                    if (fillIdx[c] == BLOCK_WORDS - 1) begin
                        checkValue("ccinv pulses", 32'(invSeen[c]), ccwrite[c] ? 32'd1 : 32'd0);
                        fillIdx[c] = 0;
                        invSeen[c] = 0;
                    end else begin
                        fillIdx[c]++;
                    end
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    initial begin
        nRST = 1'b0;
        iREN = '0;
        dREN = '0;
        dWEN = '0;
        ccwrite = '0;
        modValid = '0;
        for (int c = 0; c < 2; c++) begin
            iaddr[c] = '0;
            daddr[c] = '0;
            ownStore[c] = '0;
            modBase[c] = '0;
            modSeed[c] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fillWord(i);
        end
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;

        fork
            fetchWord(0, 32'h100);
            fetchWord(1, 32'h204);
        join
        fetchWord(0, 32'h008);
        fetchWord(1, 32'h3fc);

        writeBack(0, 32'h040, 32'ha5a5_0000);
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            fetchWord(k % 2, 32'h040 + memoryPkg::addrT'(k * memoryPkg::WORD_BYTES));
        end

        // clean read miss
        dataMiss(0, 32'h080, 1'b0);

        // core 1 holds block 0x0c0 modified
        modValid[1] = 1'b1;
        modBase[1] = 32'h0c0;
        modSeed[1] = 32'hfeed_0000;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            shadow[int'(32'h0c0 >> 2) + k] = blockWord(32'hfeed_0000, k);
        end
        dataMiss(0, 32'h0c4, 1'b0);
        modValid[1] = 1'b0;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            fetchWord(1, 32'h0c0 + memoryPkg::addrT'(k * memoryPkg::WORD_BYTES));
        end

        dataMiss(1, 32'h144, 1'b1);

        fork
            dataMiss(0, 32'h180, 1'b0);
            dataMiss(1, 32'h1c0, 1'b1);
            fetchWord(0, 32'h208);
            fetchWord(1, 32'h30c);
        join

        repeat (4) @(posedge CLK);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: busController_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module busControllerAssertions (
    input logic       CLK,
    input logic       nRST,
    input logic       ramREN,
    input logic       ramWEN,
    input logic [1:0] dREN,
    input logic [1:0] dWEN,
    input logic [1:0] dwait,
    input logic [1:0] ccwait,
    input logic [1:0] ccinv
);

    // one RAM strobe at a time
    strobeExclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(ramREN && ramWEN))
        else $error("ramREN and ramWEN high in the same cycle");

    // only the other core is ever snooped
    snoopExclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(ccwait[0] && ccwait[1]))
        else $error("ccwait high for both cores");

    invPulse: assert property (@(posedge CLK) disable iff (!nRST)
        (ccinv != 2'b00) |=> (ccinv == 2'b00))
        else $error("ccinv held for more than one cycle");

    // never invalidate a core whose own word completes
    invTarget: assert property (@(posedge CLK) disable iff (!nRST)
        (ccinv & (dREN | dWEN) & ~dwait) == 2'b00)
        else $error("ccinv sent to a core that completes a request");

endmodule

`default_nettype wire

// File: busController.sv
`timescale 1ns/1ps
`default_nettype none

module busController #(
    parameter int BLOCK_WORDS = 2,
    parameter int FETCH_CORES = 2
) (
    input  logic                   CLK,
    input  logic                   nRST,
    // instruction side
    input  logic [FETCH_CORES-1:0] iREN,
    input  memoryPkg::addrT        iaddr [FETCH_CORES],
    output logic [FETCH_CORES-1:0] iwait,
    output memoryPkg::wordT        iload [FETCH_CORES],
    // data side
    input  logic [1:0]             dREN,
    input  logic [1:0]             dWEN,
    input  memoryPkg::addrT        daddr [2],
    input  memoryPkg::wordT        dstore [2],
    output logic [1:0]             dwait,
    output memoryPkg::wordT        dload [2],
    // snoop side
    input  logic [1:0]             ccwrite,
    input  logic [1:0]             cctrans,
    output logic [1:0]             ccwait,
    output logic [1:0]             ccinv,
    output memoryPkg::addrT        ccsnoopaddr [2],
    // RAM side
    output logic                   ramREN,
    output logic                   ramWEN,
    output memoryPkg::addrT        ramaddr,
    output memoryPkg::wordT        ramstore,
    input  memoryPkg::wordT        ramload,
    input  memoryPkg::ramStateT    ramState
);

    logic                dataReq;
    logic                dataREN;
    logic                dataWEN;
    memoryPkg::addrT     dataAddr;
    memoryPkg::wordT     dataStore;
    memoryPkg::ramStateT dataRamState;
    logic                fetchReq;
    logic                fetchREN;
    memoryPkg::addrT     fetchAddr;
    memoryPkg::ramStateT fetchRamState;
    memoryPkg::wordT     portLoad;

    instrFetchPort #(
        .FETCH_CORES(FETCH_CORES)
    ) fetchPort (
        .CLK      (CLK),
        .nRST     (nRST),
        .iREN     (iREN),
        .iaddr    (iaddr),
        .ramState (fetchRamState),
        .ramload  (portLoad),
        .iwait    (iwait),
        .iload    (iload),
        .fetchReq (fetchReq),
        .fetchREN (fetchREN),
        .fetchAddr(fetchAddr)
    );

    coherentDataPort #(
        .BLOCK_WORDS(BLOCK_WORDS)
    ) dataPort (
        .CLK        (CLK),
        .nRST       (nRST),
        .dREN       (dREN),
        .dWEN       (dWEN),
        .ccwrite    (ccwrite),
        .cctrans    (cctrans),
        .daddr      (daddr),
        .dstore     (dstore),
        .ramState   (dataRamState),
        .ramload    (portLoad),
        .dwait      (dwait),
        .ccwait     (ccwait),
        .ccinv      (ccinv),
        .dload      (dload),
        .ccsnoopaddr(ccsnoopaddr),
        .dataReq    (dataReq),
        .dataREN    (dataREN),
        .dataWEN    (dataWEN),
        .dataAddr   (dataAddr),
        .dataStore  (dataStore)
    );

    ramArbiter arbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .dataReq      (dataReq),
        .dataREN      (dataREN),
        .dataWEN      (dataWEN),
        .dataAddr     (dataAddr),
        .dataStore    (dataStore),
        .fetchReq     (fetchReq),
        .fetchREN     (fetchREN),
        .fetchAddr    (fetchAddr),
        .ramload      (ramload),
        .ramState     (ramState),
        .ramREN       (ramREN),
        .ramWEN       (ramWEN),
        .ramaddr      (ramaddr),
        .ramstore     (ramstore),
        .dataRamState (dataRamState),
        .fetchRamState(fetchRamState),
        .portLoad     (portLoad)
    );

endmodule

`default_nettype wire

// File: coherentDataPort.sv
`timescale 1ns/1ps
`default_nettype none

module coherentDataPort #(
    parameter int BLOCK_WORDS = 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [1:0]          dREN,
    input  logic [1:0]          dWEN,
    input  logic [1:0]          ccwrite,
    input  logic [1:0]          cctrans,
    input  memoryPkg::addrT     daddr [2],
    input  memoryPkg::wordT     dstore [2],
    input  memoryPkg::ramStateT ramState,
    input  memoryPkg::wordT     ramload,
    output logic [1:0]          dwait,
    output logic [1:0]          ccwait,
    output logic [1:0]          ccinv,
    output memoryPkg::wordT     dload [2],
    output memoryPkg::addrT     ccsnoopaddr [2],
    output logic                dataReq,
    output logic                dataREN,
    output logic                dataWEN,
    output memoryPkg::addrT     dataAddr,
    output memoryPkg::wordT     dataStore
);

    localparam int CNT_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;
    localparam int LAST_WORD = BLOCK_WORDS - 1;
    localparam memoryPkg::addrT OFFSET_MASK =
        memoryPkg::addrT'(BLOCK_WORDS * memoryPkg::WORD_BYTES - 1);

    coherencePkg::dataStateT state;
    coherencePkg::dataStateT nextState;
    coherencePkg::dataStateT fillEntry;
    coherencePkg::dataKindT  kind;
    coherencePkg::dataKindT  pickKind;
    coherencePkg::coreIdxT   req;
    coherencePkg::coreIdxT   pick;
    coherencePkg::coreIdxT   other;
    memoryPkg::addrT         base;
    memoryPkg::addrT         wordAddr;
    logic [CNT_W-1:0]        cnt;
    logic [CNT_W-1:0]        nextCnt;
    logic                    anyReq;
    logic                    accessNow;
    logic                    lastWord;
    logic                    reqDone;

    // core 0 first, write-back ahead of a miss on the same core
    assign anyReq = |(dREN | dWEN);
    assign pick   = (dREN[0] || dWEN[0]) ? 1'b0 : 1'b1;

    always_comb begin
        if (dWEN[pick]) begin
            pickKind = coherencePkg::WRITE_BACK;
        end else if (ccwrite[pick]) begin
            pickKind = coherencePkg::WRITE_MISS;
        end else begin
            pickKind = coherencePkg::READ_MISS;
        end
    end

    assign other     = ~req;
    assign accessNow = (ramState == memoryPkg::ACCESS);
    assign lastWord  = (int'(cnt) == LAST_WORD);
    assign wordAddr  = base + memoryPkg::addrT'(int'(cnt) * memoryPkg::WORD_BYTES);

    // invalidate right before the last fill word of a write miss
    assign fillEntry = (kind == coherencePkg::WRITE_MISS && LAST_WORD == 0) ?
                       coherencePkg::INVALIDATE : coherencePkg::FILL;

    always_comb begin
        nextState = state;
        nextCnt   = cnt;
        case (state)
            coherencePkg::IDLE: begin
                if (anyReq) begin
                    nextState = (pickKind == coherencePkg::WRITE_BACK) ?
                                coherencePkg::FLUSH : coherencePkg::SNOOP;
                end
            end
            coherencePkg::SNOOP: begin
                nextState = coherencePkg::RESPOND;
            end
            coherencePkg::RESPOND: begin
                // other cache answers here
                nextState = cctrans[other] ? coherencePkg::FLUSH : fillEntry;
            end
            coherencePkg::FLUSH: begin
                if (accessNow) begin
                    if (lastWord) begin
                        nextCnt   = '0;
                        nextState = (kind == coherencePkg::WRITE_BACK) ?
                                    coherencePkg::IDLE : fillEntry;
                    end else begin
                        nextCnt = cnt + 1'b1;
                    end
                end
            end
            coherencePkg::FILL: begin
                if (accessNow) begin
                    if (lastWord) begin
                        nextCnt   = '0;
                        nextState = coherencePkg::IDLE;
                    end else begin
                        nextCnt = cnt + 1'b1;
                        if (kind == coherencePkg::WRITE_MISS &&
                            int'(cnt) + 1 == LAST_WORD) begin
                            nextState = coherencePkg::INVALIDATE;
                        end
                    end
                end
            end
            coherencePkg::INVALIDATE: begin
                nextState = coherencePkg::FILL;
            end
            default: begin
                nextState = coherencePkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= coherencePkg::IDLE;
            cnt   <= '0;
            req   <= 1'b0;
            kind  <= coherencePkg::READ_MISS;
        end else begin
            state <= nextState;
            cnt   <= nextCnt;
            if (state == coherencePkg::IDLE && anyReq) begin
                req  <= pick;
                kind <= pickKind;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == coherencePkg::IDLE) begin
            base <= daddr[pick] & ~OFFSET_MASK;
        end
    end

    // requester's word ends on a fill or on its own write-back
    assign reqDone = accessNow &&
                     (state == coherencePkg::FILL ||
                      (state == coherencePkg::FLUSH && kind == coherencePkg::WRITE_BACK));

    always_comb begin
        ccwait    = '0;
        ccinv     = '0;
        dataREN   = 1'b0;
        dataWEN   = 1'b0;
        dataAddr  = wordAddr;
        dataStore = '0;
        for (int c = 0; c < 2; c++) begin
            dload[c]       = '0;
            ccsnoopaddr[c] = '0;
        end
        case (state)
            coherencePkg::SNOOP, coherencePkg::RESPOND: begin
                ccwait[other]      = 1'b1;
                ccsnoopaddr[other] = base;
            end
            coherencePkg::FLUSH: begin
                dataWEN = 1'b1;
                if (kind == coherencePkg::WRITE_BACK) begin
                    dataAddr  = daddr[req];
                    dataStore = dstore[req];
                end else begin
                    // modified holder supplies the word at the snoop address
                    ccwait[other]      = 1'b1;
                    ccsnoopaddr[other] = wordAddr;
                    dataStore          = dstore[other];
                end
            end
            coherencePkg::FILL: begin
                dataREN    = 1'b1;
                dload[req] = ramload;
            end
            coherencePkg::INVALIDATE: begin
                ccinv[other]       = 1'b1;
                ccsnoopaddr[other] = base;
            end
            default: begin
                dataREN = 1'b0;
            end
        endcase
        for (int c = 0; c < 2; c++) begin
            dwait[c] = (dREN[c] || dWEN[c]) && !(c == int'(req) && reqDone);
        end
    end

    assign dataReq = dataREN || dataWEN;

endmodule

`default_nettype wire

// File: instrFetchPort.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetchPort #(
    parameter int FETCH_CORES = 2
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [FETCH_CORES-1:0] iREN,
    input  memoryPkg::addrT        iaddr [FETCH_CORES],
    input  memoryPkg::ramStateT    ramState,
    input  memoryPkg::wordT        ramload,
    output logic [FETCH_CORES-1:0] iwait,
    output memoryPkg::wordT        iload [FETCH_CORES],
    output logic                   fetchReq,
    output logic                   fetchREN,
    output memoryPkg::addrT        fetchAddr
);

    localparam int IDX_W = (FETCH_CORES > 1) ? $clog2(FETCH_CORES) : 1;

    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] cur;
    logic [IDX_W-1:0] pick;
    logic             anyReq;
    logic             active;
    logic             done;

    // first requester at or after the pointer
    always_comb begin
        int idx;
        pick   = ptr;
        anyReq = 1'b0;
        for (int k = FETCH_CORES - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % FETCH_CORES;
            if (iREN[idx]) begin
                pick   = IDX_W'(idx);
                anyReq = 1'b1;
            end
        end
    end

    assign fetchReq  = active && iREN[cur];
    assign fetchREN  = fetchReq;
    assign fetchAddr = iaddr[cur];
    assign done      = fetchReq && (ramState == memoryPkg::ACCESS);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            cur    <= '0;
            ptr    <= '0;
        end else if (active) begin
            if (done) begin
                active <= 1'b0;
                // next round starts past the core just served
                ptr    <= IDX_W'((int'(cur) + 1) % FETCH_CORES);
            end else if (!iREN[cur]) begin
                active <= 1'b0;
            end
        end else if (anyReq) begin
            active <= 1'b1;
            cur    <= pick;
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_CORES; i++) begin
            iwait[i] = iREN[i] && !(done && (int'(cur) == i));
            iload[i] = (int'(cur) == i) ? ramload : '0;
        end
    end

endmodule

`default_nettype wire

// File: ramArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ramArbiter (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dataReq,
    input  logic                dataREN,
    input  logic                dataWEN,
    input  memoryPkg::addrT     dataAddr,
    input  memoryPkg::wordT     dataStore,
    input  logic                fetchReq,
    input  logic                fetchREN,
    input  memoryPkg::addrT     fetchAddr,
    input  memoryPkg::wordT     ramload,
    input  memoryPkg::ramStateT ramState,
    output logic                ramREN,
    output logic                ramWEN,
    output memoryPkg::addrT     ramaddr,
    output memoryPkg::wordT     ramstore,
    output memoryPkg::ramStateT dataRamState,
    output memoryPkg::ramStateT fetchRamState,
    output memoryPkg::wordT     portLoad
);

    logic grantData;
    logic ownerData;
    logic ownerReq;
    logic holdGrant;
    logic grantedReq;

    assign ownerReq = ownerData ? dataReq : fetchReq;

    // owner keeps the RAM until its word ends on ACCESS
    always_comb begin
        if (holdGrant && ownerReq) begin
            grantData = ownerData;
        end else if (dataReq) begin
            grantData = 1'b1;
        end else if (fetchReq) begin
            grantData = 1'b0;
        end else begin
            grantData = ownerData;
        end
    end

    assign grantedReq = grantData ? dataReq : fetchReq;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ownerData <= 1'b1;
            holdGrant <= 1'b0;
        end else begin
            ownerData <= grantData;
            holdGrant <= grantedReq && (ramState != memoryPkg::ACCESS);
        end
    end

    assign ramREN   = grantData ? dataREN : fetchREN;
    assign ramWEN   = grantData && dataWEN;
    assign ramaddr  = grantData ? dataAddr : fetchAddr;
    assign ramstore = grantData ? dataStore : '0;

    // the loser only ever sees BUSY
    assign dataRamState  = grantData ? ramState : memoryPkg::BUSY;
    assign fetchRamState = grantData ? memoryPkg::BUSY : ramState;
    assign portLoad      = ramload;

endmodule

`default_nettype wire

// File: coherencePkg.sv
`default_nettype none

package coherencePkg;

    // one bit for two cores
    typedef logic coreIdxT;

    typedef enum logic [1:0] {
        READ_MISS,
        WRITE_MISS,
        WRITE_BACK
    } dataKindT;

    // data port FSM
    typedef enum logic [2:0] {
        IDLE,
        SNOOP,
        RESPOND,
        FLUSH,
        FILL,
        INVALIDATE
    } dataStateT;

endpackage

`default_nettype wire

// File: memoryPkg.sv
`default_nettype none

package memoryPkg;

    // one RAM word
    typedef logic [31:0] wordT;

    // word-aligned byte address
    typedef logic [31:0] addrT;

    // ACCESS marks the cycle the current access completes
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramStateT;

    // byte step between neighbouring words
    localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire
